/* logic/panel_pkg.sv */
// panel geometry, scan states and the panel pin bundle, imported by the scan and top modules
package panel_pkg;

	// 64 x 32 panel, driven as two halves of 16 rows
	localparam int PANEL_COLS = 64;
	localparam int HALF_ROWS = 16;

	// column within a row
	typedef logic [5:0] col_t;
	// row within one half
	typedef logic [3:0] row_t;
	// {half, row, column}, half 0 is the top
	typedef logic [10:0] fb_addr_t;

	// framebuffer words, one per panel pixel
	localparam int FB_DEPTH = 2 ** $bits(fb_addr_t);

	// per column: fetch, then one low and one high pixel clock cycle
	// per row and plane: latch, then show for the plane on-time
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		SHIFT_LO,
		SHIFT_HI,
		LATCH,
		SHOW
	} scan_state_t;

	// all HUB75 pins
	// oe is active high here (LEDs on)
	// rgb bit 0 red, bit 1 green, bit 2 blue
	typedef struct packed {
		logic       pix_clk;
		logic       latch;
		logic       oe;
		row_t       row_addr;
		logic [2:0] rgb_top;
		logic [2:0] rgb_bot;
	} panel_out_t;

endpackage

/* logic/pixel_pkg.sv */
// pixel format, bit-plane timing constants and the host-side write and config bundles
package pixel_pkg;

	// 5:6:5, red in the top bits
	typedef logic [15:0] rgb565_t;
	// bit-plane index
	typedef logic [2:0] plane_t;
	// one colour channel after widening to 6 bits
	typedef logic [5:0] chan_t;

	localparam int NUM_PLANES = 6;
	// clock cycles of LED on-time for plane 0, doubles per plane
	localparam int ON_UNIT = 8;
	// wide enough for the longest on-time
	localparam int ON_CNT_W = $clog2((ON_UNIT << (NUM_PLANES - 1)) + 1);

	// bit positions of the channels in rgb_enable and the rgb pins
	localparam int RGB_R = 0;
	localparam int RGB_G = 1;
	localparam int RGB_B = 2;

	// single-cycle write, no back-pressure
	typedef struct packed {
		logic                strobe;
		panel_pkg::fb_addr_t addr;
		rgb565_t             data;
	} fb_write_t;

	// static config level from the host
	typedef struct packed {
		logic                  scan_en;
		logic [2:0]            rgb_enable;
		logic [NUM_PLANES-1:0] plane_enable;
	} panel_cfg_t;

endpackage

/* logic/frame_ram.sv */
// framebuffer: host write port and registered scan read port on one clock
`timescale 1ns/1ps

module frame_ram (
	input  logic                  clk_root,
	input  pixel_pkg::fb_write_t  wr,
	input  panel_pkg::fb_addr_t   rd_addr,
	output pixel_pkg::rgb565_t    rd_data
);
	import panel_pkg::*;
	import pixel_pkg::*;

	// one word per panel pixel
	// top half below bottom half in the address map
	rgb565_t mem [FB_DEPTH];

	// write lands at the edge
	// visible to reads issued from the next cycle
	always_ff @(posedge clk_root) begin
		if (wr.strobe) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// one cycle read latency
	// same-address collision gives the old word
	always_ff @(posedge clk_root) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* logic/pixel_split.sv */
// picks the current bit-plane bit of each colour channel from one RGB565 pixel
`timescale 1ns/1ps

module pixel_split (
	input  pixel_pkg::rgb565_t pixel,
	input  pixel_pkg::plane_t  plane,
	input  logic [2:0]         rgb_enable,
	output logic [2:0]         rgb
);
	import pixel_pkg::*;

	chan_t red;
	chan_t green;
	chan_t blue;

	// red and blue widened to 6 bits
	// top bit repeated as the new lsb so full scale stays full
	assign red = {pixel[15:11], pixel[15]};
	assign green = pixel[10:5];
	assign blue = {pixel[4:0], pixel[4]};

	// one bit per channel, masked per colour
	assign rgb[RGB_R] = red[plane] & rgb_enable[RGB_R];
	assign rgb[RGB_G] = green[plane] & rgb_enable[RGB_G];
	assign rgb[RGB_B] = blue[plane] & rgb_enable[RGB_B];

endmodule

/* logic/plane_timer.sv */
// bit-plane on-time counter, started by the scan FSM and answering with a done pulse
`timescale 1ns/1ps

module plane_timer (
	input  logic              clk_root,
	input  logic              arst_n,
	input  logic              start,
	input  pixel_pkg::plane_t plane,
	output logic              done
);
	import pixel_pkg::*;

	// remaining cycles, zero when idle
	logic [ON_CNT_W-1:0] cnt;

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				// on-time doubles per plane
				// a restart simply reloads
				cnt <= ON_CNT_W'(ON_UNIT) << plane;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				// pulse lands in the cycle the count hits zero
				done <= (cnt == ON_CNT_W'(1));
			end
		end
	end

endmodule

/* logic/scan_fsm.sv */
// scan sequencer: walks columns, rows and bit planes, fetches pixels and drives the panel pins
`timescale 1ns/1ps

module scan_fsm (
	input  logic                  clk_root,
	input  logic                  arst_n,
	input  pixel_pkg::panel_cfg_t cfg,
	output panel_pkg::fb_addr_t   rd_addr,
	input  pixel_pkg::rgb565_t    rd_data,
	output logic                  timer_start,
	output pixel_pkg::plane_t     timer_plane,
	input  logic                  timer_done,
	output pixel_pkg::rgb565_t    pix_top,
	output pixel_pkg::rgb565_t    pix_bot,
	output pixel_pkg::plane_t     plane,
	output panel_pkg::panel_out_t ctrl
);
	import panel_pkg::*;
	import pixel_pkg::*;

	scan_state_t state;
	col_t        col_q;
	row_t        row_q;
	// row shown on the panel, only moves at latch
	row_t        row_addr_q;
	plane_t      plane_q;
	// 0: top read issued, 1: bottom read issued, 2: last read lands
	logic [1:0]  fetch_cnt;
	logic        last_col;
	logic        last_plane;
	logic        last_row;

	assign last_col = (col_q == col_t'(PANEL_COLS - 1));
	assign last_plane = (plane_q == plane_t'(NUM_PLANES - 1));
	assign last_row = (row_q == row_t'(HALF_ROWS - 1));

	// half bit follows the fetch step, top first
	assign rd_addr = {fetch_cnt[0], row_q, col_q};

	// timer starts one cycle ahead of LATCH
	// so its done pulse closes SHOW after exactly the on-time
	assign timer_start = (state == SHIFT_HI) && last_col;
	assign timer_plane = plane_q;
	assign plane = plane_q;

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			col_q <= '0;
			row_q <= '0;
			row_addr_q <= '0;
			plane_q <= '0;
			fetch_cnt <= '0;
			pix_top <= '0;
			pix_bot <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					if (cfg.scan_en) begin
						state <= FETCH;
					end
				end
				FETCH: begin
					// read data trails the address by one cycle
					if (fetch_cnt == 2'd1) begin
						pix_top <= rd_data;
					end
					if (fetch_cnt == 2'd2) begin
						pix_bot <= rd_data;
						fetch_cnt <= '0;
						state <= SHIFT_LO;
					end else begin
						fetch_cnt <= fetch_cnt + 2'd1;
					end
				end
				SHIFT_LO: begin
					state <= SHIFT_HI;
				end
				SHIFT_HI: begin
					// panel samples on this rising pix_clk
					if (last_col) begin
						col_q <= '0;
						row_addr_q <= row_q;
						state <= LATCH;
					end else begin
						col_q <= col_q + 1'b1;
						state <= FETCH;
					end
				end
				LATCH: begin
					state <= SHOW;
				end
				SHOW: begin
					if (timer_done) begin
						if (!last_plane) begin
							plane_q <= plane_q + 1'b1;
							state <= FETCH;
						end else if (!cfg.scan_en) begin
							// row boundary, park with everything cleared
							plane_q <= '0;
							row_q <= '0;
							row_addr_q <= '0;
							pix_top <= '0;
							pix_bot <= '0;
							state <= IDLE;
						end else begin
							plane_q <= '0;
							row_q <= last_row ? '0 : row_q + 1'b1;
							state <= FETCH;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// control pins straight from the state
	// plane mask only blanks oe, timing is kept
	always_comb begin
		ctrl = '0;
		ctrl.pix_clk = (state == SHIFT_HI);
		ctrl.latch = (state == LATCH);
		ctrl.oe = (state == SHOW) && cfg.plane_enable[plane_q];
		ctrl.row_addr = row_addr_q;
	end

endmodule

/* logic/led_matrix_top.sv */
// HUB75 panel driver top: framebuffer, scan FSM, plane timer and the two pixel splitters
`timescale 1ns/1ps

module led_matrix_top (
	input  logic                  clk_root,
	input  logic                  arst_n,
	input  pixel_pkg::fb_write_t  wr,
	input  pixel_pkg::panel_cfg_t cfg,
	output panel_pkg::panel_out_t panel
);
	import panel_pkg::*;
	import pixel_pkg::*;

	fb_addr_t   rd_addr;
	rgb565_t    rd_data;
	rgb565_t    pix_top;
	rgb565_t    pix_bot;
	plane_t     plane;
	plane_t     timer_plane;
	logic       timer_start;
	logic       timer_done;
	panel_out_t ctrl;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bot;

	frame_ram u_ram (
		.clk_root (clk_root),
		.wr       (wr),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	scan_fsm u_scan (
		.clk_root    (clk_root),
		.arst_n      (arst_n),
		.cfg         (cfg),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.timer_start (timer_start),
		.timer_plane (timer_plane),
		.timer_done  (timer_done),
		.pix_top     (pix_top),
		.pix_bot     (pix_bot),
		.plane       (plane),
		.ctrl        (ctrl)
	);

	plane_timer u_timer (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.start    (timer_start),
		.plane    (timer_plane),
		.done     (timer_done)
	);

	// upper half of the panel
	pixel_split split_top (
		.pixel      (pix_top),
		.plane      (plane),
		.rgb_enable (cfg.rgb_enable),
		.rgb        (rgb_top)
	);

	// lower half
	pixel_split split_bot (
		.pixel      (pix_bot),
		.plane      (plane),
		.rgb_enable (cfg.rgb_enable),
		.rgb        (rgb_bot)
	);

	// control pins from the FSM, colour from the splitters
	assign panel = '{
		pix_clk:  ctrl.pix_clk,
		latch:    ctrl.latch,
		oe:       ctrl.oe,
		row_addr: ctrl.row_addr,
		rgb_top:  rgb_top,
		rgb_bot:  rgb_bot
	};

endmodule

/* tb/clk_gen.sv */
// testbench clock and reset source, 4 ns clock with reset held low for the first 10 cycles
`timescale 1ns/1ps

module clk_gen (
	output logic clk_root,
	output logic arst_n
);

	// 250 MHz, edges every 2 ns
	initial begin
		clk_root = 1'b0;
		forever #2 clk_root = ~clk_root;
	end

	// release on a rising edge, like a synchronised reset would
	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk_root);
		arst_n <= 1'b1;
	end

endmodule

/* tb/led_matrix_sva.sv */
// protocol assertions on the HUB75 control pins, bound into the scan FSM by the testbench
`timescale 1ns/1ps

module led_matrix_sva (
	input logic                  clk_root,
	input logic                  arst_n,
	input panel_pkg::scan_state_t state,
	input panel_pkg::panel_out_t  ctrl
);
	import panel_pkg::*;

	// LEDs dark while the shift register is latched
	a_latch_oe: assert property (@(posedge clk_root) disable iff (!arst_n)
		!(ctrl.latch && ctrl.oe))
		else $error("latch and oe high in the same cycle");

	// no shift edge during the latch pulse
	a_latch_pix: assert property (@(posedge clk_root) disable iff (!arst_n)
		!(ctrl.latch && ctrl.pix_clk))
		else $error("pix_clk high in a latch cycle");

	// row lines move with the latch
	// the return to idle parks them at row 0
	a_row_hold: assert property (@(posedge clk_root) disable iff (!arst_n)
		$changed(ctrl.row_addr) |-> (ctrl.latch || state == IDLE))
		else $error("row_addr changed outside a latch cycle");

endmodule

/* tb/led_matrix_tb.sv */
// testbench for the HUB75 driver that loads the framebuffer, steps a config table and checks pins
`timescale 1ns/1ps

module led_matrix_tb;
	import panel_pkg::*;
	import pixel_pkg::*;

	// one table step with scan enable, colour mask, plane mask and rows to watch
	typedef struct packed {
		logic                  scan_en;
		logic [2:0]            rgb_enable;
		logic [NUM_PLANES-1:0] plane_enable;
		logic [7:0]            rows;
	} step_t;

	localparam int NUM_STEPS = 4;
	localparam int RESET_LIMIT = 100;
	localparam int IDLE_LIMIT = 2000;
	// longest gap between pin events is one plane-5 show plus a fetch
	localparam int QUIET_LIMIT = 400;
	localparam int IDLE_OBSERVE = 200;

	logic        clk_root;
	logic        arst_n;
	fb_write_t   wr;
	panel_cfg_t  cfg;
	panel_out_t  panel;
	// what the framebuffer should hold
	rgb565_t     model [FB_DEPTH];
	step_t       steps [NUM_STEPS];
	logic [31:0] rng;

	clk_gen u_clk (
		.clk_root (clk_root),
		.arst_n   (arst_n)
	);

	led_matrix_top uut (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.wr       (wr),
		.cfg      (cfg),
		.panel    (panel)
	);

	bind scan_fsm led_matrix_sva u_sva (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.state    (state),
		.ctrl     (ctrl)
	);

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bit k of each widened channel
	// red and blue take their msb as the extra lsb
	function automatic logic [2:0] expected_rgb(input rgb565_t p, input int k,
		input logic [2:0] en);
		logic r;
		logic g;
		logic b;
		r = (k == 0) ? p[15] : p[10 + k];
		g = p[5 + k];
		b = (k == 0) ? p[4] : p[k - 1];
		return {b & en[2], g & en[1], r & en[0]};
	endfunction

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "aborting at first error");
	endtask

	task automatic fail_with(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// in reset and idle everything is dark and parked
	task automatic check_pins_low();
		check_value("pix_clk", panel.pix_clk, 0);
		check_value("latch", panel.latch, 0);
		check_value("oe", panel.oe, 0);
		check_value("row_addr", panel.row_addr, 0);
		check_value("rgb_top", panel.rgb_top, 0);
		check_value("rgb_bot", panel.rgb_bot, 0);
	endtask

	task automatic check_reset();
		int n;
		n = 0;
		do begin
			@(negedge clk_root);
			check_pins_low();
			n++;
			if (n > RESET_LIMIT) fail_with("reset was never released");
		end while (!arst_n);
	endtask

	// one write per cycle over the whole address range
	task automatic fill_ram();
		fb_write_t w;
		for (int a = 0; a < FB_DEPTH; a++) begin
			rng = xorshift(rng);
			w.strobe = 1'b1;
			w.addr = fb_addr_t'(a);
			w.data = rng[15:0];
			model[a] = rng[15:0];
			@(posedge clk_root);
			wr <= w;
		end
		@(posedge clk_root);
		wr <= '0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (uut.u_scan.state != IDLE) begin
			@(negedge clk_root);
			n++;
			if (n > IDLE_LIMIT) fail_with("scan never returned to idle");
		end
	endtask

	task automatic watch_idle();
		repeat (IDLE_OBSERVE) begin
			@(negedge clk_root);
			check_pins_low();
		end
	endtask

	// on-time and full show length of one plane
	// extra covers what follows the show
	task automatic close_segment(input int plane, input int oe_cnt, input int gap,
		input int extra, input logic [NUM_PLANES-1:0] mask);
		int on;
		on = ON_UNIT << plane;
		check_value("oe cycles", oe_cnt, mask[plane] ? on : 0);
		check_value("show length", gap, on + extra);
	endtask

	task automatic run_scan(input step_t s);
		int        col;
		int        row;
		int        plane;
		int        latches;
		int        total;
		int        oe_cnt;
		int        gap;
		int        quiet;
		int        addr;
		logic      shown;
		logic      stop;
		logic      done;
		fb_write_t pend;
		col = 0;
		row = 0;
		plane = 0;
		latches = 0;
		total = s.rows * NUM_PLANES;
		oe_cnt = 0;
		gap = 0;
		quiet = 0;
		shown = 1'b0;
		stop = 1'b0;
		done = 1'b0;
		pend = '0;
		while (!done) begin
			@(posedge clk_root);
			wr <= pend;
			pend = '0;
			if (stop) cfg.scan_en <= 1'b0;
			@(negedge clk_root);
			quiet++;
			if (quiet > QUIET_LIMIT) fail_with("panel pins stalled during the scan");
			if (shown) gap++;
			if (panel.pix_clk) begin
				quiet = 0;
				if (latches == total) fail_with("pixel clock after the last latch");
				if (shown) begin
					// fetch of 3 cycles and shift low come before this edge
					close_segment(plane, oe_cnt, gap, 5, s.plane_enable);
					shown = 1'b0;
					plane++;
					if (plane == NUM_PLANES) begin
						plane = 0;
						row = (row + 1) % HALF_ROWS;
					end
				end
				if (col >= PANEL_COLS) fail_with("more than 64 pixel clocks before a latch");
				addr = row * PANEL_COLS + col;
				check_value("rgb_top", panel.rgb_top,
					expected_rgb(model[addr], plane, s.rgb_enable));
				check_value("rgb_bot", panel.rgb_bot,
					expected_rgb(model[addr + FB_DEPTH / 2], plane, s.rgb_enable));
				col++;
			end
			if (panel.latch) begin
				quiet = 0;
				check_value("pix_clk count", col, PANEL_COLS);
				check_value("row_addr", panel.row_addr, row);
				col = 0;
				shown = 1'b1;
				oe_cnt = 0;
				gap = 0;
				latches++;
				// live rewrite of a row 0 pixel that is seen again a frame later
				if (s.rows > HALF_ROWS && latches == NUM_PLANES) begin
					rng = xorshift(rng);
					addr = rng[5:0];
					pend.strobe = 1'b1;
					pend.addr = fb_addr_t'(addr);
					pend.data = model[addr] ^ (rng[21:6] | 16'h0001);
					model[addr] = pend.data;
				end
				if (latches == total) stop = 1'b1;
			end
			if (panel.oe) begin
				oe_cnt++;
			end
			// last plane ends in idle one cycle after the show
			if (latches == total && uut.u_scan.state == IDLE) begin
				close_segment(plane, oe_cnt, gap, 1, s.plane_enable);
				done = 1'b1;
			end
		end
	endtask

	initial begin
		wr = '0;
		cfg = '0;
		rng = 32'd66;
		// steps are full colour, idle, masked colour and planes, then one frame plus a row
		steps[0] = {1'b1, 3'b111, 6'b111111, 8'd2};
		steps[1] = {1'b0, 3'b111, 6'b111111, 8'd0};
		steps[2] = {1'b1, 3'b101, 6'b101010, 8'd1};
		steps[3] = {1'b1, 3'b111, 6'b111111, 8'd17};
		check_reset();
		fill_ram();
		for (int i = 0; i < NUM_STEPS; i++) begin
			wait_idle();
			@(posedge clk_root);
			cfg <= {steps[i].scan_en, steps[i].rgb_enable, steps[i].plane_enable};
			if (steps[i].scan_en) begin
				run_scan(steps[i]);
			end else begin
				watch_idle();
			end
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* tb.f */
logic/panel_pkg.sv
logic/pixel_pkg.sv
logic/frame_ram.sv
logic/pixel_split.sv
logic/plane_timer.sv
logic/scan_fsm.sv
logic/led_matrix_top.sv
tb/clk_gen.sv
tb/led_matrix_sva.sv
tb/led_matrix_tb.sv

/* Bender.yml */
package:
  name: led_matrix

sources:
  - files:
      - logic/panel_pkg.sv
      - logic/pixel_pkg.sv
      - logic/frame_ram.sv
      - logic/pixel_split.sv
      - logic/plane_timer.sv
      - logic/scan_fsm.sv
      - logic/led_matrix_top.sv

  - target: test
    files:
      - tb/clk_gen.sv
      - tb/led_matrix_sva.sv
      - tb/led_matrix_tb.sv
